// ==== hw/fixed_point_pkg.sv ====
//==========================================================
// Fixed point package: spectrum sample format and the
// saturating magnitude helpers used on each bin
//==========================================================
`default_nettype none

package fixed_point_pkg;

  // Signed 8.8 real and imaginary parts
  localparam int SAMPLE_W  = 16;
  localparam int FRAC_BITS = 8;
  localparam int MAG_W     = 16;

  // |x|, with the most negative code pinned to the largest positive one
  function automatic logic [SAMPLE_W-1:0] abs_sat(input logic signed [SAMPLE_W-1:0] x);
    logic signed [SAMPLE_W-1:0] most_neg;
    most_neg = {1'b1, {(SAMPLE_W-1){1'b0}}};
    if (x == most_neg) begin
      abs_sat = {1'b0, {(SAMPLE_W-1){1'b1}}};
    end else if (x < 0) begin
      abs_sat = -x;
    end else begin
      abs_sat = x;
    end
  endfunction

  // max + min/2, clipped to the magnitude range
  function automatic logic [MAG_W-1:0] mag_approx(input logic signed [SAMPLE_W-1:0] re,
                                                  input logic signed [SAMPLE_W-1:0] im);
    logic [SAMPLE_W-1:0] a;
    logic [SAMPLE_W-1:0] b;
    logic [MAG_W:0]      sum;
    a = abs_sat(re);
    b = abs_sat(im);
    if (a >= b) begin
      sum = (MAG_W+1)'(a) + (MAG_W+1)'(b >> 1);
    end else begin
      sum = (MAG_W+1)'(b) + (MAG_W+1)'(a >> 1);
    end
    mag_approx = sum[MAG_W] ? {MAG_W{1'b1}} : sum[MAG_W-1:0];
  endfunction

endpackage

`default_nettype wire

// ==== hw/classifier_pkg.sv ====
//==========================================================
// Classifier package: control states and result widths
//==========================================================
`default_nettype none

package classifier_pkg;

  // Handshake FSM states
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } ctrl_state_t;

  // Peak index width of the result
  localparam int BIN_IDX_W = 4;

  // Largest frame the index can address
  localparam int MAX_BINS = 2 ** BIN_IDX_W;

endpackage

`default_nettype wire

// ==== hw/bin_magnitude.sv ====
//==========================================================
// Bin magnitude: captures a spectrum frame and registers
// the approximate magnitude of every bin
//==========================================================
`timescale 1ns/1ps
`default_nettype none

module bin_magnitude
  import fixed_point_pkg::*;
#(
  parameter int N_BINS = 8
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         load,
  input  logic [N_BINS*2*SAMPLE_W-1:0] recv_msg,
  output logic [N_BINS*MAG_W-1:0]      mags
);

  localparam int SLOT_W = 2 * SAMPLE_W;

  logic [N_BINS*SLOT_W-1:0] frame_q;
  logic [N_BINS*MAG_W-1:0]  mags_next;
  logic                     load_d;

  //==========================================================
  // Input register
  //==========================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      frame_q <= '0;
    end else if (load) begin
      frame_q <= recv_msg;
    end
  end

  // Marks the cycle after capture, when the frame is stable
  always_ff @(posedge clk) begin
    if (reset) begin
      load_d <= 1'b0;
    end else begin
      load_d <= load;
    end
  end

  //==========================================================
  // Per-bin magnitude
  //==========================================================
  // Real part in the low half of each slot, imaginary in the high half
  for (genvar k = 0; k < N_BINS; k++) begin : g_bin
    logic signed [SAMPLE_W-1:0] re;
    logic signed [SAMPLE_W-1:0] im;

    assign re = frame_q[k*SLOT_W +: SAMPLE_W];
    assign im = frame_q[k*SLOT_W+SAMPLE_W +: SAMPLE_W];
    assign mags_next[k*MAG_W +: MAG_W] = mag_approx(re, im);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mags <= '0;
    end else if (load_d) begin
      mags <= mags_next;
    end
  end

  //==========================================================
  // Checks
  //==========================================================
  // Back-to-back frames would overwrite the input register mid-pipeline
  a_load_spaced: assert property (
    @(posedge clk) disable iff (reset) load |=> !load
  ) else $error("bin_magnitude: load asserted in two consecutive cycles");

endmodule

`default_nettype wire

// ==== hw/tone_detector.sv ====
//==========================================================
// Tone detector: highpass mask, peak search and threshold
// compare over registered bin magnitudes
//==========================================================
`timescale 1ns/1ps
`default_nettype none

module tone_detector
  import fixed_point_pkg::*;
  import classifier_pkg::*;
#(
  parameter int N_BINS     = 8,
  parameter int CUTOFF_BIN = 2,
  parameter int CUTOFF_MAG = 5120
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    detect,
  input  logic [N_BINS*MAG_W-1:0] mags,
  output logic                    tone,
  output logic [BIN_IDX_W-1:0]    peak_bin,
  output logic                    result_valid
);

  localparam logic [MAG_W-1:0] THRESH = MAG_W'(CUTOFF_MAG);

  logic [MAG_W-1:0]     best_mag;
  logic [BIN_IDX_W-1:0] best_idx;

  //==========================================================
  // Peak search over the passing bins
  //==========================================================
  // Bins below CUTOFF_BIN never enter the search.
  // Strict compare keeps the lowest index on ties
  always_comb begin
    best_mag = mags[CUTOFF_BIN*MAG_W +: MAG_W];
    best_idx = BIN_IDX_W'(CUTOFF_BIN);
    for (int k = CUTOFF_BIN + 1; k < N_BINS; k++) begin
      if (mags[k*MAG_W +: MAG_W] > best_mag) begin
        best_mag = mags[k*MAG_W +: MAG_W];
        best_idx = BIN_IDX_W'(k);
      end
    end
  end

  //==========================================================
  // Result register
  //==========================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      tone     <= 1'b0;
      peak_bin <= '0;
    end else if (detect) begin
      tone     <= best_mag > THRESH;
      peak_bin <= best_idx;
    end
  end

  // Single-cycle done strobe
  always_ff @(posedge clk) begin
    if (reset) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= detect;
    end
  end

  //==========================================================
  // Elaboration checks
  //==========================================================
  if (CUTOFF_BIN >= N_BINS) begin : g_bad_cutoff
    $error("tone_detector: CUTOFF_BIN (%0d) must be below N_BINS (%0d)",
           CUTOFF_BIN, N_BINS);
  end

  if (N_BINS < 2 || N_BINS > MAX_BINS) begin : g_bad_bins
    $error("tone_detector: N_BINS (%0d) out of range 2..%0d", N_BINS, MAX_BINS);
  end

endmodule

`default_nettype wire

// ==== hw/classifier_ctrl.sv ====
//==========================================================
// Classifier control: val/rdy handshake FSM that walks a
// frame through the magnitude and detector stages
//==========================================================
`timescale 1ns/1ps
`default_nettype none

module classifier_ctrl
  import classifier_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic recv_val,
  output logic recv_rdy,
  input  logic send_rdy,
  output logic send_val,
  output logic load,
  output logic detect,
  input  logic result_valid
);

  ctrl_state_t state;
  ctrl_state_t state_next;
  logic        calc_first;

  //==========================================================
  // State register and next state
  //==========================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // A result taken in the same cycle it appears skips DONE
  always_comb begin
    state_next = state;
    case (state)
      IDLE: if (recv_val) state_next = CALC;
      CALC: if (result_valid) state_next = send_rdy ? IDLE : DONE;
      DONE: if (send_rdy) state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  //==========================================================
  // Handshake outputs
  //==========================================================
  assign recv_rdy = (state == IDLE);
  assign load     = recv_rdy && recv_val;
  assign send_val = (state == DONE) || ((state == CALC) && result_valid);

  // Detect is issued in the first CALC cycle and lands as the
  // magnitudes get registered
  always_ff @(posedge clk) begin
    if (reset) begin
      calc_first <= 1'b0;
      detect     <= 1'b0;
    end else begin
      calc_first <= load;
      detect     <= (state == CALC) && calc_first;
    end
  end

  //==========================================================
  // Checks
  //==========================================================
  // Leaving IDLE never offers a result straight away
  a_idle_no_send: assert property (
    @(posedge clk) disable iff (reset) (state == IDLE) |=> !send_val
  ) else $error("classifier_ctrl: send_val rose on leaving IDLE");

  // Input stays blocked while the frame walks the pipeline
  a_accept_only_idle: assert property (
    @(posedge clk) disable iff (reset)
      load |=> !recv_rdy [*2] ##1 (send_val && !recv_rdy)
  ) else $error("classifier_ctrl: frame latency or input stall broken");

  // The detector must only finish a frame the FSM is waiting on
  a_result_in_calc: assert property (
    @(posedge clk) disable iff (reset) result_valid |-> (state == CALC)
  ) else $error("classifier_ctrl: result_valid outside CALC");

endmodule

`default_nettype wire

// ==== hw/classifier.sv ====
//==========================================================
// Spectral tone classifier: flags a tone above threshold in
// the passing bins of one frame and reports the peak bin
//==========================================================
`timescale 1ns/1ps
`default_nettype none

module classifier
  import fixed_point_pkg::*;
  import classifier_pkg::*;
#(
  parameter int N_BINS     = 8,
  parameter int CUTOFF_BIN = 2,
  // 20.0 in 8.8
  parameter int CUTOFF_MAG = 20 << FRAC_BITS
) (
  input  logic                         clk,
  input  logic                         reset,

  input  logic                         recv_val,
  output logic                         recv_rdy,
  input  logic [N_BINS*2*SAMPLE_W-1:0] recv_msg,

  output logic                         send_val,
  input  logic                         send_rdy,
  output logic                         send_msg,
  output logic [BIN_IDX_W-1:0]         send_bin
);

  logic                    load;
  logic                    detect;
  logic                    result_valid;
  logic [N_BINS*MAG_W-1:0] mags;

  // Handshake FSM
  classifier_ctrl ctrl_i (
    .clk          (clk),
    .reset        (reset),
    .recv_val     (recv_val),
    .recv_rdy     (recv_rdy),
    .send_rdy     (send_rdy),
    .send_val     (send_val),
    .load         (load),
    .detect       (detect),
    .result_valid (result_valid)
  );

  // Frame capture and magnitudes
  bin_magnitude #(
    .N_BINS (N_BINS)
  ) mag_i (
    .clk      (clk),
    .reset    (reset),
    .load     (load),
    .recv_msg (recv_msg),
    .mags     (mags)
  );

  // Highpass, peak and threshold
  tone_detector #(
    .N_BINS     (N_BINS),
    .CUTOFF_BIN (CUTOFF_BIN),
    .CUTOFF_MAG (CUTOFF_MAG)
  ) det_i (
    .clk          (clk),
    .reset        (reset),
    .detect       (detect),
    .mags         (mags),
    .tone         (send_msg),
    .peak_bin     (send_bin),
    .result_valid (result_valid)
  );

endmodule

`default_nettype wire

// ==== testbench/classifier_model.svh ====
//==========================================================
// Classifier reference model: magnitude, highpass mask,
// threshold and peak rules for checking DUT results
//==========================================================
`ifndef CLASSIFIER_MODEL_SVH
`define CLASSIFIER_MODEL_SVH

// Signed part of bin k, half 0 real and half 1 imaginary
function automatic int model_part(input logic [FRAME_W-1:0] f, input int k, input int half);
  logic signed [SAMPLE_W-1:0] v;
  v = f[(2*k+half)*SAMPLE_W +: SAMPLE_W];
  return int'(v);
endfunction

// Most negative code pins to the largest positive value
function automatic int model_abs(input int x);
  if (x == -(1 << (SAMPLE_W-1))) begin
    return (1 << (SAMPLE_W-1)) - 1;
  end
  return (x < 0) ? -x : x;
endfunction

// Larger part plus half the smaller, clipped to MAG_W bits
function automatic int model_mag(input int re, input int im);
  int a;
  int b;
  int m;
  a = model_abs(re);
  b = model_abs(im);
  m = (a > b) ? a + b / 2 : b + a / 2;
  if (m > (1 << MAG_W) - 1) begin
    m = (1 << MAG_W) - 1;
  end
  return m;
endfunction

// Peak over bins from CUTOFF_BIN up; first index wins a tie
function automatic void model_result(input logic [FRAME_W-1:0] f, output bit tone,
                                     output int peak);
  int best;
  int m;
  best = -1;
  peak = CUTOFF_BIN;
  for (int k = CUTOFF_BIN; k < N_BINS; k++) begin
    m = model_mag(model_part(f, k, 0), model_part(f, k, 1));
    if (m > best) begin
      best = m;
      peak = k;
    end
  end
  tone = best > CUTOFF_MAG;
endfunction

`endif

// ==== testbench/classifier_tb.sv ====
//==========================================================
// Classifier testbench: random frames with back-pressure,
// checked against a reference model
//==========================================================
`timescale 1ns/1ps
`default_nettype none

module classifier_tb
  import fixed_point_pkg::*;
  import classifier_pkg::*;
();

  localparam int N_BINS         = 8;
  localparam int CUTOFF_BIN     = 2;
  localparam int CUTOFF_MAG     = 20 * 256;
  localparam int FRAME_W        = N_BINS * 2 * SAMPLE_W;
  localparam int CLK_PERIOD     = 8;
  localparam int NUM_FRAMES     = 200;
  localparam int FRAME_CYCLES   = 40;
  localparam int MAX_WAIT       = 20;
  localparam int FIRST_SEND     = 3;
  localparam int SAT_MAG        = 32767 + 32767 / 2;
  localparam int KIND_LOW_HUGE  = 4;
  localparam int KIND_SATURATED = 5;

  logic                 clk;
  logic                 reset;
  logic                 recv_val;
  logic                 recv_rdy;
  logic [FRAME_W-1:0]   recv_msg;
  logic                 send_val;
  logic                 send_rdy;
  logic                 send_msg;
  logic [BIN_IDX_W-1:0] send_bin;
  logic [FRAME_W-1:0]   frame;
  int                   seed;

  `include "classifier_model.svh"

  classifier classifier_i (
    .clk      (clk),
    .reset    (reset),
    .recv_val (recv_val),
    .recv_rdy (recv_rdy),
    .recv_msg (recv_msg),
    .send_val (send_val),
    .send_rdy (send_rdy),
    .send_msg (send_msg),
    .send_bin (send_bin)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  initial begin
    #(NUM_FRAMES * FRAME_CYCLES * CLK_PERIOD);
    $display("The run timed out before all frames were processed");
    $display("Errors found");
    $fatal(1, "watchdog expired");
  end

  task automatic check_value(input int actual, input int expected, input string what);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s: got %0d, expected %0d", $time, what, actual, expected);
      $display("Errors found");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic report_hang(input string what);
    $display("The DUT did not answer in time at %0t ns: %s", $time, what);
    $display("Errors found");
    $fatal(1, "handshake timeout");
  endtask

  function automatic int random_in(input int span);
    return $random(seed) % span;
  endfunction

  function automatic int extreme_value();
    case ({$random(seed)} % 4)
      0: return -32768;
      1: return 32767;
      2: return -32767;
      default: return 0;
    endcase
  endfunction

  task automatic set_bin(input int k, input int re, input int im);
    frame[2*k*SAMPLE_W +: SAMPLE_W]     = SAMPLE_W'(re);
    frame[(2*k+1)*SAMPLE_W +: SAMPLE_W] = SAMPLE_W'(im);
  endtask

  //==========================================================
  // Frame builders
  //==========================================================
  task automatic build_frame(input int kind);
    int scale;
    int re;
    int im;
    int k_tie;
    scale = 1024 + int'({$random(seed)} % 4096);
    re    = 4000 + int'({$random(seed)} % 4000);
    im    = random_in(4000);
    for (int k = 0; k < N_BINS; k++) begin
      case (kind)
        0: set_bin(k, $random(seed), $random(seed));
        // Near the threshold, so some frames cross and some do not
        1: set_bin(k, random_in(scale), random_in(scale));
        2: set_bin(k, extreme_value(), extreme_value());
        KIND_LOW_HUGE: begin
          if (k < CUTOFF_BIN) begin
            set_bin(k, -32768, -32768);
          end else begin
            set_bin(k, random_in(1000), random_in(1000));
          end
        end
        KIND_SATURATED: set_bin(k, -32768, -32768);
        default: set_bin(k, random_in(500), random_in(500));
      endcase
    end
    // Equal magnitudes dropped into random bins
    if (kind == 3) begin
      repeat (3) begin
        k_tie = int'({$random(seed)} % N_BINS);
        case ({$random(seed)} % 4)
          0: set_bin(k_tie, re, im);
          1: set_bin(k_tie, im, re);
          2: set_bin(k_tie, -re, im);
          default: set_bin(k_tie, re, -im);
        endcase
      end
    end
  endtask

  //==========================================================
  // One frame through both handshakes
  //==========================================================
  task automatic run_frame(input int rdy_delay);
    bit exp_tone;
    int exp_peak;
    int n;
    bit taken;
    model_result(frame, exp_tone, exp_peak);
    recv_val = 1'b1;
    recv_msg = frame;
    n = 0;
    @(negedge clk);
    while (!recv_rdy) begin
      n++;
      if (n > MAX_WAIT) begin
        report_hang("recv_rdy stayed low");
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    // Junk on the bus must not reach the captured frame
    recv_val = 1'b0;
    recv_msg = {(FRAME_W/32){$random(seed)}};
    n = 0;
    taken = 1'b0;
    while (!taken) begin
      n++;
      if (n > MAX_WAIT) begin
        report_hang("no output transfer");
      end
      send_rdy = (n >= FIRST_SEND + rdy_delay);
      @(negedge clk);
      check_value(int'(recv_rdy), 0, "recv_rdy while a frame is in flight");
      check_value(int'(send_val), int'(n >= FIRST_SEND), "send_val timing");
      if (n >= FIRST_SEND) begin
        check_value(int'(send_msg), int'(exp_tone), "tone flag");
        check_value(int'(send_bin), exp_peak, "peak bin");
      end
      if (n == FIRST_SEND) begin
        for (int k = 0; k < N_BINS; k++) begin
          check_value(int'(classifier_i.mags[k*MAG_W +: MAG_W]),
                      model_mag(model_part(frame, k, 0), model_part(frame, k, 1)),
                      $sformatf("magnitude of bin %0d", k));
        end
      end
      taken = send_val && send_rdy;
      @(posedge clk);
      #1;
    end
    send_rdy = 1'b0;
    check_value(int'(recv_rdy), 1, "recv_rdy after output transfer");
    check_value(int'(send_val), 0, "send_val after output transfer");
  endtask

  //==========================================================
  // Test sequence
  //==========================================================
  initial begin
    seed     = 32'h52dc_a470;
    reset    = 1'b1;
    recv_val = 1'b0;
    recv_msg = '0;
    send_rdy = 1'b0;
    frame    = '0;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    check_value(int'(recv_rdy), 1, "recv_rdy after reset");
    check_value(int'(send_val), 0, "send_val after reset");
    @(posedge clk);
    #1;

    // Huge bins below the cutoff stay invisible
    build_frame(KIND_LOW_HUGE);
    run_frame(1);
    check_value(int'(send_msg), 0, "tone from masked bins");
    check_value(int'(send_bin >= CUTOFF_BIN), 1, "peak in a masked bin");

    build_frame(KIND_SATURATED);
    run_frame(2);
    check_value(int'(classifier_i.mags[CUTOFF_BIN*MAG_W +: MAG_W]), SAT_MAG,
                "saturated magnitude");

    for (int i = 2; i < NUM_FRAMES; i++) begin
      build_frame(int'({$random(seed)} % 4));
      run_frame(int'({$random(seed)} % 9) - 2);
      repeat ({$random(seed)} % 3) begin
        @(posedge clk);
        #1;
      end
    end

    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== classifier.f ====
+incdir+testbench
hw/fixed_point_pkg.sv
hw/classifier_pkg.sv
hw/bin_magnitude.sv
hw/tone_detector.sv
hw/classifier_ctrl.sv
hw/classifier.sv
testbench/classifier_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the classifier testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module classifier_tb -f classifier.f

# Keep the simulator output so it can be searched after the run
sim_out=$(./obj_dir/Vclassifier_tb 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qxF "No errors"; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
